/* src/ciPkg.sv */
`default_nettype none

package ciPkg;

  // ----------------------------------------
  // instruction port widths
  // ----------------------------------------
  localparam int ciWidth       = 32;
  localparam int ciNumberWidth = 8;

  // custom instruction numbers kept in this design, anything else is unknown
  typedef enum logic [ciNumberWidth-1:0] {
    opSwapByte  = 8'd1,
    opDelay     = 8'd6,
    opGrayscale = 8'd12
  } ciOpcodeT;

  // ----------------------------------------
  // request and response bundles
  // ----------------------------------------

  // one request as the processor issues it, start is a single-cycle strobe
  typedef struct packed {
    logic               start;
    ciOpcodeT           opcode;
    logic [ciWidth-1:0] dataA;
    logic [ciWidth-1:0] dataB;
  } ciRequestT;

  // result must read zero in every cycle where done is low
  typedef struct packed {
    logic               done;
    logic [ciWidth-1:0] result;
  } ciResponseT;

endpackage

`default_nettype wire

/* src/timingPkg.sv */
`default_nettype none

package timingPkg;

  // reset is released once the top counter bit sets, 16 cycles after lock
  localparam int resetCountWidth = 5;

  // scaled microsecond so that simulation stays short
  localparam int cyclesPerMicrosecond = 4;
  localparam int prescaleWidth        = $clog2(cyclesPerMicrosecond);

  // only the low bits of operand A give the delay length
  localparam int delayWidth = 16;

endpackage

`default_nettype wire

/* src/resetSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module resetSequencer
  import timingPkg::*;
(
  input  wire logic s_systemClock,
  input  wire logic s_pllLocked,
  output logic      internalReset,
  output logic      peripheralResetN
);

  logic [resetCountWidth-1:0] resetCount;
  logic                       released;

  assign released         = resetCount[resetCountWidth-1];
  assign internalReset    = ~released;
  assign peripheralResetN = released;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!released) begin
      resetCount <= resetCount + 1'b1; // stops counting once the top bit is set
    end
  end

  // a lost lock is the only way back into reset
  releaseHolds : assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    peripheralResetN |=> peripheralResetN);

endmodule

`default_nettype wire

/* src/delayTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module delayTimer
  import timingPkg::*;
(
  input  wire logic                  s_systemClock,
  input  wire logic                  s_pllLocked,
  input  wire logic                  internalReset,
  input  wire logic                  delayStart,
  input  wire logic [delayWidth-1:0] delayMicroseconds,
  output logic                       delayExpired
);

  logic [prescaleWidth-1:0] prescaleCount;
  logic [delayWidth-1:0]    microsecondCount;
  logic                     running;
  logic                     tick;

  // tick marks the last system cycle of each microsecond
  assign tick         = running && (prescaleCount == prescaleWidth'(cyclesPerMicrosecond - 1));
  assign delayExpired = tick && (microsecondCount == delayWidth'(1));

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      running          <= 1'b0;
      prescaleCount    <= '0;
      microsecondCount <= '0;
    end else if (internalReset) begin
      running          <= 1'b0;
      prescaleCount    <= '0;
      microsecondCount <= '0;
    end else if (delayStart) begin
      running          <= (delayMicroseconds != '0); // a zero delay never runs
      prescaleCount    <= '0;
      microsecondCount <= delayMicroseconds;
    end else if (tick) begin
      prescaleCount    <= '0;
      microsecondCount <= microsecondCount - 1'b1;
      if (microsecondCount == delayWidth'(1)) begin
        running <= 1'b0;
      end
    end else if (running) begin
      prescaleCount <= prescaleCount + 1'b1;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // an idle timer needs a full microsecond before it can expire
  noIdleExpiry : assert property (@(posedge s_systemClock)
    disable iff (!s_pllLocked || internalReset)
    !running |=> !delayExpired);

  // expiry always ends the run
  expiryStops : assert property (@(posedge s_systemClock)
    disable iff (!s_pllLocked || internalReset)
    delayExpired && !delayStart |=> !running);

endmodule

`default_nettype wire

/* src/pixelDataUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelDataUnit
  import ciPkg::*;
(
  input  wire logic [ciWidth-1:0] operandA,
  output logic [ciWidth-1:0]      swapResult,
  output logic [ciWidth-1:0]      grayResult
);

  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;
  logic [7:0]  gray;

  // ----------------------------------------
  // byte swap
  // ----------------------------------------
  assign swapResult = {operandA[7:0], operandA[15:8], operandA[23:16], operandA[31:24]};

  // ----------------------------------------
  // RGB565 grayscale
  // ----------------------------------------

  // widen the channels to 8 bits, low bits stay zero
  assign red   = {operandA[15:11], 3'b000};
  assign green = {operandA[10:5], 2'b00};
  assign blue  = {operandA[4:0], 3'b000};

  // weights sum to 256 so the worst case still fits in 16 bits
  assign weightedSum = 16'd54 * {8'd0, red}
                     + 16'd183 * {8'd0, green}
                     + 16'd19 * {8'd0, blue};

  assign gray = weightedSum[15:8];

  // gray is packed back as RGB565 so the screen can show it directly
  assign grayResult = {16'd0, gray[7:3], gray[7:2], gray[7:3]};

endmodule

`default_nettype wire

/* src/ciController.sv */
`timescale 1ns/1ps
`default_nettype none

module ciController
  import ciPkg::*;
  import timingPkg::*;
(
  input  wire logic                  s_systemClock,
  input  wire logic                  s_pllLocked,
  input  wire logic                  internalReset,
  input  wire ciRequestT             ciRequest,
  input  wire logic [ciWidth-1:0]    swapResult,
  input  wire logic [ciWidth-1:0]    grayResult,
  input  wire logic                  delayExpired,
  output logic                       delayStart,
  output logic [delayWidth-1:0]      delayMicroseconds,
  output ciResponseT                 ciResponse
);

  typedef enum logic [1:0] {
    idle,
    delaying,
    respond
  } ciControllerStateT;

  ciControllerStateT     state;
  logic [ciWidth-1:0]    resultReg;
  logic [delayWidth-1:0] requestedDelay;
  logic                  accept;

  // ----------------------------------------
  // request decode
  // ----------------------------------------
  assign requestedDelay = ciRequest.dataA[delayWidth-1:0]; // upper bits of A are ignored
  assign accept         = ciRequest.start && (state == idle);

  // the timer loads in the same edge that accepts the request
  assign delayStart        = accept && (ciRequest.opcode == opDelay) && (requestedDelay != '0);
  assign delayMicroseconds = requestedDelay;

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state     <= idle;
      resultReg <= '0;
    end else if (internalReset) begin
      state     <= idle;
      resultReg <= '0;
    end else begin
      case (state)
        idle: begin
          if (ciRequest.start) begin
            state <= delayStart ? delaying : respond;
            case (ciRequest.opcode)
              opSwapByte:  resultReg <= swapResult;
              opGrayscale: resultReg <= grayResult;
              default:     resultReg <= '0; // delay and unknown numbers answer zero
            endcase
          end
        end
        delaying: begin
          if (delayExpired) begin
            state <= respond;
          end
        end
        respond: begin
          state     <= idle;
          resultReg <= '0; // keeps the result bus quiet between answers
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  assign ciResponse = '{done: (state == respond), result: resultReg};

  // ----------------------------------------
  // checks
  // ----------------------------------------
  donePulse : assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    ciResponse.done |=> !ciResponse.done);

  quietResult : assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !ciResponse.done |-> (ciResponse.result == '0));

endmodule

`default_nettype wire

/* src/ciSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module ciSubsystem
  import ciPkg::*;
  import timingPkg::*;
(
  input  wire logic      s_systemClock,
  input  wire logic      s_pllLocked,
  input  wire ciRequestT ciRequest,
  output ciResponseT     ciResponse,
  output logic           peripheralResetN
);

  logic                  internalReset;
  logic                  delayStart;
  logic                  delayExpired;
  logic [delayWidth-1:0] delayMicroseconds;
  logic [ciWidth-1:0]    swapResult;
  logic [ciWidth-1:0]    grayResult;

  resetSequencer resetSeq0 (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .internalReset    (internalReset),
    .peripheralResetN (peripheralResetN)
  );

  ciController controller0 (
    .s_systemClock     (s_systemClock),
    .s_pllLocked       (s_pllLocked),
    .internalReset     (internalReset),
    .ciRequest         (ciRequest),
    .swapResult        (swapResult),
    .grayResult        (grayResult),
    .delayExpired      (delayExpired),
    .delayStart        (delayStart),
    .delayMicroseconds (delayMicroseconds),
    .ciResponse        (ciResponse)
  );

  delayTimer delay0 (
    .s_systemClock     (s_systemClock),
    .s_pllLocked       (s_pllLocked),
    .internalReset     (internalReset),
    .delayStart        (delayStart),
    .delayMicroseconds (delayMicroseconds),
    .delayExpired      (delayExpired)
  );

  // both pixel results are ready in the cycle the start arrives
  pixelDataUnit pixel0 (
    .operandA   (ciRequest.dataA),
    .swapResult (swapResult),
    .grayResult (grayResult)
  );

endmodule

`default_nettype wire

/* bench/ciSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module ciSubsystemTb
  import ciPkg::*;
  import timingPkg::*;
();

  localparam int maxTests    = 64;
  localparam int randomTests = 8;
  localparam int gapCycles   = 3; // quiet cycles watched after every answer

  logic       s_systemClock;
  logic       s_pllLocked;
  ciRequestT  ciRequest;
  ciResponseT ciResponse;
  logic       peripheralResetN;

  string       testName [maxTests];
  logic [7:0]  testNumber [maxTests];
  logic [31:0] testA [maxTests];
  logic [31:0] testB [maxTests];
  logic [31:0] testExpected [maxTests];
  int          testCount;
  int          passCount;
  int          failCount;
  int          errorCount;
  int          cycleCount;
  int          cycleLimit;
  integer      seed;
  logic        lastDone;

  ciSubsystem dut0 (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .ciRequest        (ciRequest),
    .ciResponse       (ciResponse),
    .peripheralResetN (peripheralResetN)
  );

  initial s_systemClock = 1'b0;
  always #2 s_systemClock = ~s_systemClock;

  always @(posedge s_systemClock) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout: the run went past its limit of %0d cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------
  // response rules that hold in every cycle
  // ----------------------------------------
  always @(negedge s_systemClock) begin
    if (cycleCount > 0) begin // the clock starts with a falling edge before the first cycle
      assert (!(ciResponse.done && lastDone))
        else begin
          $display("ERROR: done stayed high for more than one cycle at %0t", $time);
          errorCount++;
        end
      assert (ciResponse.done || ciResponse.result == '0)
        else begin
          $display("ERROR: result is %h while done is low at %0t", ciResponse.result, $time);
          errorCount++;
        end
      assert (peripheralResetN || !ciResponse.done) // nothing answers while held in reset
        else begin
          $display("ERROR: done pulsed before the reset was released at %0t", $time);
          errorCount++;
        end
      lastDone = ciResponse.done;
    end
  end

  function automatic logic [31:0] reverseBytes(input logic [31:0] value);
    return {value[7:0], value[15:8], value[23:16], value[31:24]};
  endfunction

  task automatic loadTestFile();
    int    fd;
    int    fields;
    int    delayN;
    string line;
    string nameText;
    logic [31:0] number;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
    testCount  = 0;
    cycleLimit = 100 + randomTests * 10; // reset phase plus the random swaps
    fd = $fopen("bench/ciTests.txt", "r");
    if (fd == 0) begin
      $display("ERROR: bench/ciTests.txt could not be opened");
    end else begin
      while (!$feof(fd) && testCount < maxTests) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          fields = $sscanf(line, "%s %h %h %h %h", nameText, number, a, b, expected);
          if (fields == 5) begin
            testName[testCount]     = nameText;
            testNumber[testCount]   = number[7:0];
            testA[testCount]        = a;
            testB[testCount]        = b;
            testExpected[testCount] = expected;
            delayN = (number[7:0] == 8'd6) ? int'(a[15:0]) : 0;
            cycleLimit += delayN * cyclesPerMicrosecond + 10;
            testCount++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic releaseReset();
    int   waitCycles;
    logic quiet;
    quiet       = 1'b1;
    s_pllLocked = 1'b0;
    repeat (3) @(negedge s_systemClock);
    s_pllLocked = 1'b1;
    @(negedge s_systemClock);
    ciRequest.start  = 1'b1; // must be ignored while the counter runs
    ciRequest.opcode = opSwapByte;
    ciRequest.dataA  = 32'hA5A5_0F0F;
    @(negedge s_systemClock);
    ciRequest.start = 1'b0;
    if (ciResponse.done) quiet = 1'b0;
    waitCycles = 2;
    while (!peripheralResetN && waitCycles < 20) begin
      @(negedge s_systemClock);
      if (ciResponse.done) quiet = 1'b0;
      waitCycles++;
    end
    repeat (gapCycles) begin
      @(negedge s_systemClock);
      if (ciResponse.done) quiet = 1'b0;
    end
    assert (peripheralResetN && waitCycles >= 16)
      else $display("ERROR: peripheralResetN did not rise 16 to 20 cycles after PLL lock");
    assert (quiet) else $display("ERROR: a start during reset produced a done pulse");
    if (peripheralResetN && waitCycles >= 16 && quiet) begin
      passCount++;
      $display("resetRelease: PASS after %0d cycles", waitCycles);
    end else begin
      failCount++;
      $display("resetRelease: FAIL");
    end
  endtask

  task automatic runInstruction(input string name, input logic [7:0] number,
                                input logic [31:0] dataA, input logic [31:0] dataB,
                                input logic [31:0] expected);
    int   latency;
    int   minLatency;
    int   maxLatency;
    int   delayN;
    int   extraDones;
    logic [31:0] actual;
    logic ok;
    ok         = 1'b1;
    extraDones = 0;
    delayN     = (number == 8'd6) ? int'(dataA[15:0]) : 0;
    minLatency = delayN * cyclesPerMicrosecond;
    maxLatency = (delayN == 0) ? 0 : minLatency + 3;
    ciRequest.start  = 1'b1;
    ciRequest.opcode = ciOpcodeT'(number);
    ciRequest.dataA  = dataA;
    ciRequest.dataB  = dataB;
    @(negedge s_systemClock);
    ciRequest.start = 1'b0;
    latency = 0;
    while (!ciResponse.done && latency < maxLatency + 8) begin
      if (delayN >= 2 && latency == 2) begin
        ciRequest.start  = 1'b1; // second start while the delay is still running
        ciRequest.opcode = opSwapByte;
      end else begin
        ciRequest.start = 1'b0;
      end
      @(negedge s_systemClock);
      latency++;
    end
    ciRequest.start = 1'b0;
    actual = ciResponse.result;
    assert (ciResponse.done)
      else begin
        $display("ERROR: %0s got no done pulse within %0d cycles", name, latency);
        ok = 1'b0;
      end
    if (ciResponse.done) begin
      assert (latency >= minLatency && latency <= maxLatency)
        else begin
          $display("ERROR: %0s answered after %0d cycles, allowed %0d to %0d",
                   name, latency, minLatency, maxLatency);
          ok = 1'b0;
        end
      assert (actual === expected)
        else begin
          $display("MISMATCH %0s: expected %h, actual %h", name, expected, actual);
          ok = 1'b0;
        end
    end
    repeat (gapCycles) begin
      @(negedge s_systemClock);
      if (ciResponse.done) extraDones++;
    end
    assert (extraDones == 0)
      else begin
        $display("ERROR: %0s produced %0d extra done pulses", name, extraDones);
        ok = 1'b0;
      end
    if (ok) begin
      passCount++;
      $display("%0s: PASS after %0d cycles", name, latency);
    end else begin
      failCount++;
      $display("%0s: FAIL", name);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    logic [31:0] randomA;
    s_pllLocked = 1'b0;
    ciRequest   = '0;
    passCount   = 0;
    failCount   = 0;
    errorCount  = 0;
    cycleCount  = 0;
    lastDone    = 1'b0;
    seed        = 53136;
    loadTestFile();
    if (testCount == 0) begin
      $display("ERROR: no tests could be read from bench/ciTests.txt");
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      releaseReset();
      for (int i = 0; i < testCount; i++) begin
        runInstruction(testName[i], testNumber[i], testA[i], testB[i], testExpected[i]);
      end
      for (int i = 0; i < randomTests; i++) begin
        randomA = $random(seed);
        runInstruction($sformatf("randomSwap%0d", i), 8'd1, randomA, ~randomA,
                       reverseBytes(randomA));
      end
      $display("tests passed: %0d, tests failed: %0d, cycle errors: %0d",
               passCount, failCount, errorCount);
      if (failCount == 0 && errorCount == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bench/ciTests.txt */
# name  number  operandA  operandB  expected
# every value after the name is hex, delay length is the low 16 bits of operandA
swapCount       01 12345678 00000000 78563412
swapDead        01 DEADBEEF 11111111 EFBEADDE
swapLowByte     01 000000FF FFFFFFFF FF000000
swapSequence    01 01020304 CAFEF00D 04030201
swapZero        01 00000000 12345678 00000000
grayRed         0C 0000F800 00000000 000031A6
grayGreen       0C 000007E0 00000000 0000B5B6
grayBlue        0C 0000001F 00000000 00001082
grayWhite       0C 0000FFFF 00000000 0000FFDF
grayBlack       0C 00000000 00000000 00000000
grayMid         0C 00008410 00000000 00008410
grayHighBits    0C ABCDF800 55555555 000031A6
delayZero       06 00000000 00000000 00000000
delayOne        06 00000001 00000000 00000000
delayTwo        06 00000002 FFFFFFFF 00000000
delayFive       06 00000005 00000000 00000000
delayHighBits   06 12340003 00000000 00000000
unknownZero     00 12345678 87654321 00000000
unknownTwo      02 DEADBEEF 00000000 00000000
unknownSeven    07 0000F800 00000000 00000000
unknownMax      FF FFFFFFFF FFFFFFFF 00000000
swapAfterDelay  01 A1B2C3D4 00000000 D4C3B2A1
grayAfterSwap   0C 00008410 00000000 00008410

/* src.f */
src/ciPkg.sv
src/timingPkg.sv
src/resetSequencer.sv
src/delayTimer.sv
src/pixelDataUnit.sv
src/ciController.sv
src/ciSubsystem.sv
bench/ciSubsystemTb.sv

/* Bender.yml */
package:
  name: ci_subsystem

sources:
  - files:
      - src/ciPkg.sv
      - src/timingPkg.sv
      - src/resetSequencer.sv
      - src/delayTimer.sv
      - src/pixelDataUnit.sv
      - src/ciController.sv
      - src/ciSubsystem.sv
  - target: test
    files:
      - bench/ciSubsystemTb.sv
